// ==== build.f ====
hw/rv32i_pkg.sv
hw/ctrl_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/control.sv
hw/datapath.sv
hw/rv32i_cpu.sv
tb/rv32i_cpu_assert.sv
tb/rv32i_cpu_tb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import rv32i_pkg::*;
(
    input  alu_ops         aluop,
    input  rv32i_word      a,
    input  rv32i_word      b,
    output rv32i_word      f,
    input  branch_funct3_t cmpop,
    input  rv32i_word      c1,
    input  rv32i_word      c2,
    output logic           br_en
);

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_sll: f = a << b[4:0];
            alu_sra: f = rv32i_word'($signed(a) >>> b[4:0]);
            alu_sub: f = a - b;
            alu_xor: f = a ^ b;
            alu_srl: f = a >> b[4:0];
            alu_or:  f = a | b;
            default: f = a & b;
        endcase
    end

    always_comb begin
        case (cmpop)
            beq:     br_en = (c1 == c2);
            bne:     br_en = (c1 != c2);
            blt:     br_en = ($signed(c1) < $signed(c2));
            bge:     br_en = ($signed(c1) >= $signed(c2));
            bltu:    br_en = (c1 < c2);
            bgeu:    br_en = (c1 >= c2);
            default: br_en = 1'b0; // Reserved funct3 never taken.
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  decode_t    dec,
    input  logic       mem_resp,
    output ctrl_word_t ctrl,
    output logic       mem_read,
    output logic       mem_write,
    output logic [3:0] mem_byte_enable
);

    typedef enum logic [3:0] {
        FETCH1, FETCH2, FETCH3, DECODE,
        LUI, AUIPC, JAL, JALR, BR, IMM, REG,
        CALC_ADDR, LD1, LD2, ST1, ST2
    } state_t;

    state_t state, next_state;

    branch_funct3_t branch_funct3;
    load_funct3_t   load_funct3;
    store_funct3_t  store_funct3;
    arith_funct3_t  arith_funct3;
    alu_ops         alu_op;
    logic [3:0]     wmask;

    assign branch_funct3 = branch_funct3_t'(dec.funct3);
    assign load_funct3   = load_funct3_t'(dec.funct3);
    assign store_funct3  = store_funct3_t'(dec.funct3);
    assign arith_funct3  = arith_funct3_t'(dec.funct3);
    assign alu_op        = alu_ops'(dec.funct3);

    always_comb begin
        case (store_funct3)
            sw:      wmask = 4'b1111;
            sh:      wmask = dec.byte_in_word[1] ? 4'b1100 : 4'b0011;
            sb:      wmask = 4'b0001 << dec.byte_in_word; // One lane per byte offset.
            default: wmask = 4'b0000;
        endcase
    end

    function void set_defaults();
        ctrl = '0;
        ctrl.pcmux_sel = pcmux_pc_plus4;
        ctrl.alumux1_sel = alumux1_rs1_out;
        ctrl.alumux2_sel = alumux2_i_imm;
        ctrl.regfilemux_sel = rfmux_alu_out;
        ctrl.marmux_sel = marmux_pc_out;
        ctrl.cmpmux_sel = cmpmux_rs2_out;
        ctrl.aluop = alu_op;
        ctrl.cmpop = branch_funct3;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_byte_enable = 4'b1111;
    endfunction

    function void set_pc(pcmux_sel_t sel);
        ctrl.load_pc = 1'b1;
        ctrl.pcmux_sel = sel;
    endfunction

    function void set_regfile(regfilemux_sel_t sel);
        ctrl.load_regfile = 1'b1;
        ctrl.regfilemux_sel = sel;
    endfunction

    function void set_mar(marmux_sel_t sel);
        ctrl.load_mar = 1'b1;
        ctrl.marmux_sel = sel;
    endfunction

    function void set_alu(alumux1_sel_t sel1, alumux2_sel_t sel2, alu_ops op);
        ctrl.alumux1_sel = sel1;
        ctrl.alumux2_sel = sel2;
        ctrl.aluop = op;
    endfunction

    function void set_cmp(cmpmux_sel_t sel, branch_funct3_t op);
        ctrl.cmpmux_sel = sel;
        ctrl.cmpop = op;
    endfunction

    // Shared by IMM and REG, which differ only in the second operand.
    function void arith_ops(alumux2_sel_t sel2, cmpmux_sel_t csel, logic allow_sub);
        case (arith_funct3)
            slt: begin
                set_cmp(csel, blt);
                set_regfile(rfmux_br_en);
            end
            sltu: begin
                set_cmp(csel, bltu);
                set_regfile(rfmux_br_en);
            end
            sr: begin
                set_alu(alumux1_rs1_out, sel2, dec.funct7[5] ? alu_sra : alu_srl);
                set_regfile(rfmux_alu_out);
            end
            add: begin
                set_alu(alumux1_rs1_out, sel2,
                        (allow_sub && dec.funct7[5]) ? alu_sub : alu_add);
                set_regfile(rfmux_alu_out);
            end
            default: begin
                set_alu(alumux1_rs1_out, sel2, alu_op);
                set_regfile(rfmux_alu_out);
            end
        endcase
        set_pc(pcmux_pc_plus4);
    endfunction

    always_comb begin
        set_defaults();
        case (state)
            FETCH1: set_mar(marmux_pc_out);
            FETCH2: begin
                mem_read = 1'b1;
                ctrl.load_mdr = mem_resp; // Latch only on the response.
            end
            FETCH3: ctrl.load_ir = 1'b1;
            LUI: begin
                set_pc(pcmux_pc_plus4);
                set_regfile(rfmux_u_imm);
            end
            AUIPC: begin
                set_alu(alumux1_pc_out, alumux2_u_imm, alu_add);
                set_pc(pcmux_pc_plus4);
                set_regfile(rfmux_alu_out);
            end
            JAL: begin
                set_alu(alumux1_pc_out, alumux2_j_imm, alu_add);
                set_pc(pcmux_alu_out);
                set_regfile(rfmux_pc_plus4); // Link is old PC plus 4.
            end
            JALR: begin
                set_alu(alumux1_rs1_out, alumux2_i_imm, alu_add);
                set_pc(pcmux_alu_mod2);
                set_regfile(rfmux_pc_plus4);
            end
            BR: begin
                set_alu(alumux1_pc_out, alumux2_b_imm, alu_add);
                set_cmp(cmpmux_rs2_out, branch_funct3);
                set_pc(pcmux_sel_t'({1'b0, dec.br_en})); // Taken selects the target.
            end
            IMM: arith_ops(alumux2_i_imm, cmpmux_i_imm, 1'b0);
            REG: arith_ops(alumux2_rs2_out, cmpmux_rs2_out, 1'b1);
            CALC_ADDR: begin
                set_mar(marmux_alu_out);
                if (dec.opcode == op_store) begin
                    ctrl.load_data_out = 1'b1;
                    set_alu(alumux1_rs1_out, alumux2_s_imm, alu_add);
                end else begin
                    set_alu(alumux1_rs1_out, alumux2_i_imm, alu_add);
                end
            end
            LD1: begin
                mem_read = 1'b1;
                ctrl.load_mdr = mem_resp;
            end
            LD2: begin
                case (load_funct3)
                    lb:      set_regfile(rfmux_lb);
                    lbu:     set_regfile(rfmux_lbu);
                    lh:      set_regfile(rfmux_lh);
                    lhu:     set_regfile(rfmux_lhu);
                    lw:      set_regfile(rfmux_lw);
                    default: ;
                endcase
                set_pc(pcmux_pc_plus4);
            end
            ST1: begin
                mem_write = 1'b1;
                mem_byte_enable = wmask;
            end
            ST2: set_pc(pcmux_pc_plus4);
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            FETCH1: next_state = FETCH2;
            FETCH2: next_state = mem_resp ? FETCH3 : FETCH2;
            FETCH3: next_state = DECODE;
            DECODE: begin
                case (dec.opcode)
                    op_lui:   next_state = LUI;
                    op_auipc: next_state = AUIPC;
                    op_jal:   next_state = JAL;
                    op_jalr:  next_state = JALR;
                    op_br:    next_state = BR;
                    op_imm:   next_state = IMM;
                    op_reg:   next_state = REG;
                    op_load,
                    op_store: next_state = CALC_ADDR;
                    default:  next_state = FETCH1; // Unknown opcode returns to fetch.
                endcase
            end
            CALC_ADDR: next_state = (dec.opcode == op_store) ? ST1 : LD1;
            LD1:       next_state = mem_resp ? LD2 : LD1;
            ST1:       next_state = mem_resp ? ST2 : ST1;
            default:   next_state = FETCH1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH1;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    import rv32i_pkg::*;

    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'b00,
        pcmux_alu_out  = 2'b01, // Branch code relies on this being 1.
        pcmux_alu_mod2 = 2'b10  // JALR target with bit 0 cleared.
    } pcmux_sel_t;

    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm   = 3'b000,
        alumux2_u_imm   = 3'b001,
        alumux2_b_imm   = 3'b010,
        alumux2_s_imm   = 3'b011,
        alumux2_j_imm   = 3'b100,
        alumux2_rs2_out = 3'b101
    } alumux2_sel_t;

    typedef enum logic [3:0] {
        rfmux_alu_out  = 4'd0,
        rfmux_br_en    = 4'd1,
        rfmux_u_imm    = 4'd2,
        rfmux_pc_plus4 = 4'd3,
        rfmux_lb       = 4'd4,
        rfmux_lbu      = 4'd5,
        rfmux_lh       = 4'd6,
        rfmux_lhu      = 4'd7,
        rfmux_lw       = 4'd8
    } regfilemux_sel_t;

    typedef enum logic {
        marmux_pc_out  = 1'b0,
        marmux_alu_out = 1'b1
    } marmux_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef struct packed {
        pcmux_sel_t      pcmux_sel;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        regfilemux_sel_t regfilemux_sel;
        marmux_sel_t     marmux_sel;
        cmpmux_sel_t     cmpmux_sel;
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        logic            load_pc;
        logic            load_ir;
        logic            load_regfile;
        logic            load_mar;
        logic            load_mdr;
        logic            load_data_out;
    } ctrl_word_t;

    typedef struct packed {
        rv32i_opcode opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic        br_en;
        logic [1:0]  byte_in_word; // Low MAR bits.
    } decode_t;

endpackage

`default_nettype wire

// ==== hw/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ctrl_word_t ctrl,
    input  rv32i_word  mem_rdata,
    output decode_t    dec,
    output rv32i_word  mem_address,
    output rv32i_word  mem_wdata
);

    rv32i_word pc, ir, mar, mdr, data_out;
    rv32i_word i_imm, s_imm, b_imm, u_imm, j_imm;
    rv32i_word rs1_out, rs2_out, alu_a, alu_b, alu_f, cmp_b;
    rv32i_word pc_plus4, pc_next, rf_in, mdr_shift;
    logic      br_en;

    assign i_imm = {{21{ir[31]}}, ir[30:20]};
    assign s_imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
    assign b_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign u_imm = {ir[31:12], 12'h000};
    assign j_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    assign pc_plus4  = pc + 32'd4;
    assign mdr_shift = mdr >> {mar[1:0], 3'b000}; // Addressed byte to bit 0.

    always_comb begin
        case (ctrl.pcmux_sel)
            pcmux_alu_out:  pc_next = alu_f;
            pcmux_alu_mod2: pc_next = {alu_f[31:1], 1'b0};
            default:        pc_next = pc_plus4;
        endcase

        alu_a = (ctrl.alumux1_sel == alumux1_pc_out) ? pc : rs1_out;

        case (ctrl.alumux2_sel)
            alumux2_u_imm:   alu_b = u_imm;
            alumux2_b_imm:   alu_b = b_imm;
            alumux2_s_imm:   alu_b = s_imm;
            alumux2_j_imm:   alu_b = j_imm;
            alumux2_rs2_out: alu_b = rs2_out;
            default:         alu_b = i_imm;
        endcase

        cmp_b = (ctrl.cmpmux_sel == cmpmux_i_imm) ? i_imm : rs2_out;

        case (ctrl.regfilemux_sel)
            rfmux_br_en:    rf_in = {31'b0, br_en};
            rfmux_u_imm:    rf_in = u_imm;
            rfmux_pc_plus4: rf_in = pc_plus4;
            rfmux_lb:       rf_in = {{24{mdr_shift[7]}}, mdr_shift[7:0]};
            rfmux_lbu:      rf_in = {24'b0, mdr_shift[7:0]};
            rfmux_lh:       rf_in = {{16{mdr_shift[15]}}, mdr_shift[15:0]};
            rfmux_lhu:      rf_in = {16'b0, mdr_shift[15:0]};
            rfmux_lw:       rf_in = mdr;
            default:        rf_in = alu_f;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (ctrl.load_pc) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir) ir <= mdr;
        if (ctrl.load_mdr) mdr <= mem_rdata;
        if (ctrl.load_data_out) data_out <= rs2_out;
        if (ctrl.load_mar) begin
            mar <= (ctrl.marmux_sel == marmux_alu_out) ? alu_f : pc;
        end
    end

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .load    (ctrl.load_regfile),
        .rs1     (ir[19:15]),
        .rs2     (ir[24:20]),
        .rd      (ir[11:7]),
        .in      (rf_in),
        .rs1_out (rs1_out),
        .rs2_out (rs2_out)
    );

    alu u_alu (
        .aluop (ctrl.aluop),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f),
        .cmpop (ctrl.cmpop),
        .c1    (rs1_out),
        .c2    (cmp_b),
        .br_en (br_en)
    );

    assign dec.opcode       = rv32i_opcode'(ir[6:0]);
    assign dec.funct3       = ir[14:12];
    assign dec.funct7       = ir[31:25];
    assign dec.br_en        = br_en;
    assign dec.byte_in_word = mar[1:0];

    assign mem_address = mar;
    assign mem_wdata   = data_out << {mar[1:0], 3'b000}; // Into the store lane.

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  rv32i_word  in,
    output rv32i_word  rs1_out,
    output rv32i_word  rs2_out
);

    rv32i_word data [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                data[i] <= '0;
            end
        end else if (load && rd != 5'd0) begin
            data[rd] <= in; // x0 never written.
        end
    end

    assign rs1_out = (rs1 == 5'd0) ? '0 : data[rs1];
    assign rs2_out = (rs2 == 5'd0) ? '0 : data[rs2];

endmodule

`default_nettype wire

// ==== hw/rv32i_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_cpu
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rv32i_word  mem_rdata,
    input  logic       mem_resp,
    output rv32i_word  mem_address,
    output rv32i_word  mem_wdata,
    output logic       mem_read,
    output logic       mem_write,
    output logic [3:0] mem_byte_enable
);

    ctrl_word_t ctrl; // Controller to datapath.
    decode_t    dec;  // Datapath back to controller.

    control u_control (
        .clk             (clk),
        .rst             (rst),
        .dec             (dec),
        .mem_resp        (mem_resp),
        .ctrl            (ctrl),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    datapath u_datapath (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .mem_rdata   (mem_rdata),
        .dec         (dec),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== hw/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0] rv32i_word;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111, // Load upper immediate.
        op_auipc = 7'b0010111, // Add upper immediate to PC.
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011, // Conditional branches.
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011, // Register-immediate arithmetic.
        op_reg   = 7'b0110011  // Register-register arithmetic.
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000, // Also sub when funct7[5] is set.
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // srl or sra by funct7[5].
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // Arithmetic funct3 maps straight onto these; sub and sra fill the slt slots.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module rv32i_cpu_tb -f build.f -o sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1 || true
grep -qx "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== tb/rv32i_cpu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_cpu_assert
    import rv32i_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      mem_read,
    input logic      mem_write,
    input logic      mem_resp,
    input rv32i_word mem_address
);

    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    // A request waits for its response with the address held.
    read_held: assert property (@(posedge clk) disable iff (rst)
        mem_read && !mem_resp |=> mem_read && $stable(mem_address))
        else $error("read request dropped or address changed before mem_resp");

    write_held: assert property (@(posedge clk) disable iff (rst)
        mem_write && !mem_resp |=> mem_write && $stable(mem_address))
        else $error("write request dropped or address changed before mem_resp");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !mem_read && !mem_write)
        else $error("memory strobe high in the first cycle after reset");

endmodule

bind rv32i_cpu rv32i_cpu_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_resp    (mem_resp),
    .mem_address (mem_address)
);

`default_nettype wire

// ==== tb/rv32i_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_cpu_tb
    import rv32i_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       mem_resp;
    logic       mem_read;
    logic       mem_write;
    logic [3:0] mem_byte_enable;
    rv32i_word  mem_rdata;
    rv32i_word  mem_address;
    rv32i_word  mem_wdata;

    rv32i_word  mem [256];
    rv32i_word  exp_addr [$];
    rv32i_word  exp_data [$];
    logic [3:0] exp_be [$];
    logic [31:0] lfsr;
    logic [1:0] delay;
    logic       busy;
    rv32i_word  halt_pc;
    logic       fetched;
    int         prog_len = 0;
    int         store_idx = 0;
    int         errors = 0;
    int         cycles;

    rv32i_cpu dut_i (
        .clk             (clk),
        .rst             (rst),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h80200003;
        return out;
    endfunction

    function automatic logic [1:0] random_wait();
        logic [1:0] v;
        v[0] = lfsr_bit();
        v[1] = lfsr_bit();
        return v;
    endfunction

    function automatic rv32i_word r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
    endfunction

    function automatic rv32i_word i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic rv32i_word s_type(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op_store};
    endfunction

    function automatic rv32i_word b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op_br};
    endfunction

    function automatic rv32i_word u_type(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic rv32i_word j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    function automatic rv32i_word byte_mask(logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic emit(input rv32i_word ins);
        mem[prog_len[7:0]] = ins;
        prog_len++;
    endtask

    task automatic store_regs(input int first, input int last, input int offset);
        for (int r = first; r <= last; r++) begin
            emit(s_type(offset + (r - first) * 4, r, 2, 2)); // sw xr to x2 area.
        end
    endtask

    task automatic build_program();
        int f3s [6];
        int ra [3];
        int rb [3];
        f3s = '{0, 1, 4, 5, 6, 7};
        ra = '{3, 4, 3};
        rb = '{4, 3, 3};
        emit(i_type(800, 0, 0, 1, op_imm)); // Data base 0x320.
        emit(i_type(896, 0, 0, 2, op_imm)); // Store area 0x380.
        emit(i_type(-7, 0, 0, 3, op_imm));
        emit(i_type(5, 0, 0, 4, op_imm));
        emit(r_type(32, 4, 3, 0, 5)); // sub
        emit(i_type(1025, 3, 5, 6, op_imm)); // srai
        emit(i_type(1, 3, 5, 7, op_imm));
        emit(r_type(0, 4, 3, 2, 8));
        emit(r_type(0, 4, 3, 3, 9));
        emit(i_type(-8, 3, 2, 10, op_imm));
        emit(i_type(-1, 4, 3, 11, op_imm));
        emit(r_type(0, 4, 3, 4, 12));
        emit(r_type(0, 4, 4, 1, 13));
        emit(r_type(32, 4, 3, 5, 14)); // sra
        emit(r_type(0, 4, 3, 5, 15));
        emit(i_type(240, 3, 6, 16, op_imm));
        emit(i_type(240, 3, 7, 17, op_imm));
        emit(r_type(0, 4, 3, 0, 18));
        emit(r_type(0, 4, 3, 6, 19));
        emit(r_type(0, 4, 3, 7, 20));
        emit(i_type(2047, 3, 4, 21, op_imm));
        emit(i_type(3, 3, 1, 22, op_imm));
        emit(i_type(-3, 4, 0, 23, op_imm));
        store_regs(5, 23, 0);
        for (int k = 0; k < 4; k++) begin
            emit(i_type(k, 1, 0, 5 + k, op_load)); // lb
            emit(i_type(k, 1, 4, 9 + k, op_load)); // lbu
        end
        emit(i_type(0, 1, 1, 13, op_load));
        emit(i_type(2, 1, 1, 14, op_load));
        emit(i_type(0, 1, 5, 15, op_load));
        emit(i_type(2, 1, 5, 16, op_load));
        emit(i_type(4, 1, 2, 17, op_load));
        store_regs(5, 17, 0);
        for (int k = 0; k < 4; k++) begin
            emit(s_type(80 + k, 17, 2, 0));
        end
        emit(s_type(84, 17, 2, 1));
        emit(s_type(86, 17, 2, 1));
        emit(s_type(88, 17, 2, 2));
        emit(i_type(80, 2, 2, 18, op_load)); // Reads back the merged sb bytes.
        emit(s_type(92, 18, 2, 2));
        emit(i_type(0, 0, 0, 20, op_imm));
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                emit(b_type(8, rb[p], ra[p], f3s[k]));
                emit(i_type(1, 20, 0, 20, op_imm)); // Skipped when taken.
                emit(i_type(1, 20, 1, 20, op_imm));
            end
        end
        emit(s_type(96, 20, 2, 2));
        emit(u_type(32'habcde, 24, op_lui));
        emit(i_type(291, 24, 0, 24, op_imm));
        emit(u_type(32'h12345, 25, op_auipc));
        emit(j_type(8, 21));
        emit(i_type(1, 20, 0, 20, op_imm));
        emit(u_type(0, 22, op_auipc));
        emit(i_type(13, 22, 0, 23, op_jalr)); // Odd target drops bit 0.
        emit(i_type(2, 20, 0, 20, op_imm));
        store_regs(20, 25, 100);
        emit(j_type(0, 0)); // Halt loop.
    endtask

    // ISA-level model of the image; records every store in order.
    function automatic void rv32i_ref();
        rv32i_word  m [256];
        rv32i_word  x [32];
        rv32i_word  pc, npc, ins, a, b, r, addr, w, lane;
        rv32i_word  i_imm, s_imm, b_imm, u_imm, j_imm;
        logic [3:0] be;
        logic       take;
        logic       wr;
        m = mem;
        x = '{default: '0};
        pc = '0;
        halt_pc = '1;
        for (int steps = 0; steps < 4000; steps++) begin
            ins = m[pc[9:2]];
            if (ins == 32'h0000006f) begin
                halt_pc = pc;
                break;
            end
            i_imm = {{20{ins[31]}}, ins[31:20]};
            s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            u_imm = {ins[31:12], 12'b0};
            j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            npc = pc + 32'd4;
            wr = 1'b1;
            r = '0;
            case (ins[6:0])
                op_lui:   r = u_imm;
                op_auipc: r = pc + u_imm;
                op_jal: begin
                    r = pc + 32'd4;
                    npc = pc + j_imm;
                end
                op_jalr: begin
                    r = pc + 32'd4;
                    npc = (a + i_imm) & ~32'd1;
                end
                op_br: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'd0:    take = (a == b);
                        3'd1:    take = (a != b);
                        3'd4:    take = ($signed(a) < $signed(b));
                        3'd5:    take = ($signed(a) >= $signed(b));
                        3'd6:    take = (a < b);
                        default: take = (a >= b);
                    endcase
                    if (take) npc = pc + b_imm;
                end
                op_load: begin
                    addr = a + i_imm;
                    w = m[addr[9:2]] >> {addr[1:0], 3'b000};
                    case (ins[14:12])
                        3'd0:    r = {{24{w[7]}}, w[7:0]};
                        3'd4:    r = {24'b0, w[7:0]};
                        3'd1:    r = {{16{w[15]}}, w[15:0]};
                        3'd5:    r = {16'b0, w[15:0]};
                        default: r = w;
                    endcase
                end
                op_store: begin
                    wr = 1'b0;
                    addr = a + s_imm;
                    case (ins[14:12])
                        3'd0:    be = 4'b0001 << addr[1:0];
                        3'd1:    be = 4'b0011 << addr[1:0];
                        default: be = 4'b1111;
                    endcase
                    lane = b << {addr[1:0], 3'b000};
                    for (int k = 0; k < 4; k++) begin
                        if (be[k]) m[addr[9:2]][8*k +: 8] = lane[8*k +: 8];
                    end
                    exp_addr.push_back(addr);
                    exp_be.push_back(be);
                    exp_data.push_back(lane & byte_mask(be));
                end
                op_imm, op_reg: begin
                    if (!ins[5]) b = i_imm; // Immediate form.
                    case (ins[14:12])
                        3'd0:    r = (ins[5] && ins[30]) ? a - b : a + b;
                        3'd1:    r = a << b[4:0];
                        3'd2:    r = {31'b0, $signed(a) < $signed(b)};
                        3'd3:    r = {31'b0, a < b};
                        3'd4:    r = a ^ b;
                        3'd5:    r = ins[30] ? rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'd6:    r = a | b;
                        default: r = a & b;
                    endcase
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = r;
            pc = npc;
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory with 0 to 3 wait cycles per request.
    initial begin
        mem_resp = 1'b0;
        mem_rdata = '0;
        busy = 1'b0;
        delay = '0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_resp) begin
                mem_resp = 1'b0;
            end else if (!rst && (mem_read || mem_write)) begin
                if (!busy) begin
                    busy = 1'b1;
                    delay = random_wait();
                end
                if (delay == 2'd0) begin
                    busy = 1'b0;
                    mem_resp = 1'b1;
                    if (mem_write) begin
                        for (int k = 0; k < 4; k++) begin
                            if (mem_byte_enable[k]) begin
                                mem[mem_address[9:2]][8*k +: 8] = mem_wdata[8*k +: 8];
                            end
                        end
                    end else begin
                        mem_rdata = mem[mem_address[9:2]];
                    end
                end else begin
                    delay = delay - 2'd1;
                end
            end
        end
    end

    // Store checker sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst && mem_write && mem_resp) begin
            if (store_idx >= exp_addr.size()) begin
                $display("Unexpected store to address %h beyond the expected sequence",
                         mem_address);
                errors++;
            end else begin
                if (mem_address !== exp_addr[store_idx]) begin
                    $display("[FAIL] mem_address got %h expected %h",
                             mem_address, exp_addr[store_idx]);
                    errors++;
                end
                if (mem_byte_enable !== exp_be[store_idx]) begin
                    $display("[FAIL] mem_byte_enable got %h expected %h",
                             mem_byte_enable, exp_be[store_idx]);
                    errors++;
                end
                if ((mem_wdata & byte_mask(exp_be[store_idx])) !== exp_data[store_idx]) begin
                    $display("[FAIL] mem_wdata got %h expected %h",
                             mem_wdata & byte_mask(exp_be[store_idx]), exp_data[store_idx]);
                    errors++;
                end
            end
            store_idx++;
        end
    end

    initial begin
        rst = 1'b1;
        lfsr = 32'h71d75e0b;
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = (i * 32'h9e3779b1) ^ 32'h5a5a5a5a;
        end
        mem[200] = 32'hf18a7f83; // Load operands with mixed sign bytes.
        mem[201] = 32'hc3b2a196;
        build_program();
        rv32i_ref();
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        cycles = 0;
        while (store_idx < exp_addr.size() && cycles < 40000) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < exp_addr.size()) begin
            $display("Timeout: only %0d of %0d stores seen", store_idx, exp_addr.size());
            errors++;
        end else begin
            // No further store may come before the core reaches the halt loop.
            cycles = 0;
            fetched = 1'b0;
            while (!fetched && cycles < 200) begin
                @(negedge clk);
                fetched = mem_read && mem_resp && (mem_address == halt_pc);
                cycles++;
            end
            if (!fetched) begin
                $display("Timeout: halt instruction at %h never fetched", halt_pc);
                errors++;
            end
        end
        $display("Stores checked: %0d, errors: %0d", store_idx, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
